//--- Bender.yml
package:
  name: lowmap

sources:
  # packages first, then the RTL
  - hw/bus_pkg.sv
  - hw/map_pkg.sv
  - hw/addr_mapper.sv
  - hw/reg_bank_slot.sv
  - hw/resp_collect.sv
  - hw/lowmap_top.sv
  - target: test
    files:
      - test/lowmap_checker.sv
      - test/tb_lowmap.sv

//--- files.f
hw/bus_pkg.sv
hw/map_pkg.sv
hw/addr_mapper.sv
hw/reg_bank_slot.sv
hw/resp_collect.sv
hw/lowmap_top.sv
test/lowmap_checker.sv
test/tb_lowmap.sv

//--- hw/addr_mapper.sv
// ====================
// host request latch and region decoder
// strobes one slot, or the miss path, for one cycle
// ====================

`timescale 1ns/1ps

module addr_mapper (
        input  logic                          clk,
        input  logic                          rst,
        input  logic [bus_pkg::data_w-1:0]    a,
        input  logic [bus_pkg::data_w-1:0]    d,
        input  logic [bus_pkg::be_w-1:0]      web,
        input  logic                          rd,
        output logic                          ready,
        output logic                          start,
        output logic [map_pkg::num_slots-1:0] slot_stb,
        output logic                          miss_stb,
        output logic [bus_pkg::be_w-1:0]      slot_we_be,
        output logic [map_pkg::idx_w-1:0]     slot_idx,
        output logic [bus_pkg::data_w-1:0]    slot_wdata,
        input  logic                          done
);
        import bus_pkg::*;
        import map_pkg::*;

        logic                 busy;
        logic                 req;
        logic                 issue;
        bus_addr_u            a_r;
        logic [data_w-1:0]    d_r;
        logic [be_w-1:0]      web_r;
        logic                 rd_r;
        logic [num_slots-1:0] slot_hit;

        // any lane enable or a read strobe is a request
        assign req = (|web) | rd;
        assign ready = ~busy & ~req;
        assign start = ~busy & req;

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy <= 1'b0;
                        web_r <= '0;
                        rd_r <= 1'b0;
                end else if (!busy) begin
                        if (req) begin
                                busy <= 1'b1;
                                web_r <= web;
                                // a write wins over a read
                                rd_r <= rd & ~(|web);
                        end
                end else begin
                        // enables live for the strobe cycle only
                        web_r <= '0;
                        rd_r <= 1'b0;
                        if (done) begin
                                busy <= 1'b0;
                        end
                end
        end

        // request payload
        always_ff @(posedge clk) begin
                if (start) begin
                        a_r.raw <= a;
                        d_r <= d;
                end
        end

        // first busy cycle
        assign issue = busy & ((|web_r) | rd_r);

        // region compare against every slot
        always_comb begin
                slot_hit = '0;
                for (int i = 0; i < num_slots; i++) begin
                        slot_hit[i] = (a_r.f.region == 16'(region_base + i * region_stride));
                end
        end

        assign slot_stb = issue ? slot_hit : '0;
        assign miss_stb = issue & ~(|slot_hit);

        assign slot_we_be = web_r;
        assign slot_idx = a_r.f.offset[idx_lsb +: idx_w];
        assign slot_wdata = d_r;

        a_stb_onehot: assert property (@(posedge clk) disable iff (rst)
                $onehot0({slot_stb, miss_stb}))
                else $error("more than one strobe target");

        // a strobe only follows the edge that accepted a request
        a_stb_busy: assert property (@(posedge clk) disable iff (rst)
                ((|slot_stb) || miss_stb) |-> $past(start))
                else $error("strobe without an accepted request");

        // a strobe is never repeated within one transfer
        a_stb_single: assert property (@(posedge clk) disable iff (rst)
                ((|slot_stb) || miss_stb) |=> !((|slot_stb) || miss_stb))
                else $error("strobe held for two cycles");

endmodule

//--- hw/bus_pkg.sv
// ====================
// host bus widths and the request address view
// shared by the RTL and the testbench
// ====================

package bus_pkg;

        // one bus word, also the address width
        localparam int unsigned data_w = 32;

        // byte-lane write enables
        localparam int unsigned be_w = 4;
        localparam int unsigned lane_w = data_w / be_w;

        // address halves
        localparam int unsigned region_w = data_w / 2;
        localparam int unsigned offset_w = data_w - region_w;

        // an address is either a raw word or a region/offset pair
        typedef union packed {
                logic [data_w-1:0] raw;
                struct packed {
                        logic [region_w-1:0] region;
                        logic [offset_w-1:0] offset;
                } f;
        } bus_addr_u;

endpackage

//--- hw/lowmap_top.sv
// ====================
// peripheral decoder top with its register-bank slots
// ====================

`timescale 1ns/1ps

module lowmap_top (
        input  logic                       clk,
        input  logic                       rst,
        input  logic [bus_pkg::data_w-1:0] a,
        input  logic [bus_pkg::data_w-1:0] d,
        input  logic [bus_pkg::be_w-1:0]   web,
        input  logic                       rd,
        output logic [bus_pkg::data_w-1:0] spo,
        output logic                       ready
);
        import bus_pkg::*;
        import map_pkg::*;

        logic                                start;
        logic                                done;
        logic                                miss_stb;
        logic [num_slots-1:0]                slot_stb;
        logic [be_w-1:0]                     slot_we_be;
        logic [idx_w-1:0]                    slot_idx;
        logic [data_w-1:0]                   slot_wdata;
        logic [num_slots-1:0]                slot_ack;
        logic [num_slots-1:0][data_w-1:0]    slot_rdata;

        addr_mapper u_mapper (
                .clk        (clk),
                .rst        (rst),
                .a          (a),
                .d          (d),
                .web        (web),
                .rd         (rd),
                .ready      (ready),
                .start      (start),
                .slot_stb   (slot_stb),
                .miss_stb   (miss_stb),
                .slot_we_be (slot_we_be),
                .slot_idx   (slot_idx),
                .slot_wdata (slot_wdata),
                .done       (done)
        );

        // one bank per mapped region
        for (genvar i = 0; i < num_slots; i++) begin : g_slot
                reg_bank_slot u_slot (
                        .clk   (clk),
                        .rst   (rst),
                        .stb   (slot_stb[i]),
                        .we_be (slot_we_be),
                        .idx   (slot_idx),
                        .wdata (slot_wdata),
                        .ack   (slot_ack[i]),
                        .rdata (slot_rdata[i])
                );
        end

        resp_collect u_collect (
                .clk        (clk),
                .rst        (rst),
                .start      (start),
                .miss_stb   (miss_stb),
                .slot_ack   (slot_ack),
                .slot_rdata (slot_rdata),
                .spo        (spo),
                .done       (done)
        );

endmodule

//--- hw/map_pkg.sv
// ====================
// address map of the register-bank peripherals
// ====================

package map_pkg;

        // number of register-bank peripherals
        localparam int unsigned num_slots = 4;

        // words per bank
        localparam int unsigned slot_words = 16;
        localparam int unsigned idx_w = $clog2(slot_words);

        // word index sits above the byte address bits
        // higher offset bits are ignored, so the bank aliases
        localparam int unsigned idx_lsb = 2;

        // slot i owns region_base + i * region_stride
        localparam logic [15:0] region_base = 16'h9200;
        localparam logic [15:0] region_stride = 16'h0100;

        // answer for a region that no slot owns
        localparam logic [31:0] unmapped_data = 32'hdeadbeef;

endpackage

//--- hw/reg_bank_slot.sv
// ====================
// word-addressed register bank with byte-lane writes
// ====================

`timescale 1ns/1ps

module reg_bank_slot (
        input  logic                       clk,
        input  logic                       rst,
        input  logic                       stb,
        input  logic [bus_pkg::be_w-1:0]   we_be,
        input  logic [map_pkg::idx_w-1:0]  idx,
        input  logic [bus_pkg::data_w-1:0] wdata,
        output logic                       ack,
        output logic [bus_pkg::data_w-1:0] rdata
);
        import bus_pkg::*;
        import map_pkg::*;

        logic [data_w-1:0] mem [slot_words];
        logic              is_write;

        assign is_write = |we_be;

        // bank contents and acknowledge
        always_ff @(posedge clk) begin
                if (rst) begin
                        ack <= 1'b0;
                        for (int w = 0; w < slot_words; w++) begin
                                mem[w] <= '0;
                        end
                end else begin
                        ack <= stb;
                        if (stb && is_write) begin
                                // merge only the enabled lanes
                                for (int b = 0; b < be_w; b++) begin
                                        if (we_be[b]) begin
                                                mem[idx][b*lane_w +: lane_w] <=
                                                        wdata[b*lane_w +: lane_w];
                                        end
                                end
                        end
                end
        end

        // read word, zero for a write
        always_ff @(posedge clk) begin
                if (stb) begin
                        if (is_write) begin
                                rdata <= '0;
                        end else begin
                                rdata <= mem[idx];
                        end
                end
        end

        a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
                ack |=> !ack)
                else $error("ack held for two cycles");

endmodule

//--- hw/resp_collect.sv
// ====================
// gathers the answer of the strobed slot or the miss path
// registers it for the host and ends the transfer
// ====================

`timescale 1ns/1ps

module resp_collect (
        input  logic                                                clk,
        input  logic                                                rst,
        input  logic                                                start,
        input  logic                                                miss_stb,
        input  logic [map_pkg::num_slots-1:0]                       slot_ack,
        input  logic [map_pkg::num_slots-1:0][bus_pkg::data_w-1:0] slot_rdata,
        output logic [bus_pkg::data_w-1:0]                          spo,
        output logic                                                done
);
        import bus_pkg::*;
        import map_pkg::*;

        logic              miss_ack;
        logic              any_ack;
        logic [data_w-1:0] ack_data;

        // the miss path answers with the same latency as a slot
        always_ff @(posedge clk) begin
                if (rst) begin
                        miss_ack <= 1'b0;
                end else begin
                        miss_ack <= miss_stb;
                end
        end

        assign any_ack = (|slot_ack) | miss_ack;

        // fixed pattern unless a slot answers
        always_comb begin
                ack_data = unmapped_data;
                for (int i = 0; i < num_slots; i++) begin
                        if (slot_ack[i]) begin
                                ack_data = slot_rdata[i];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        spo <= '0;
                        done <= 1'b0;
                end else begin
                        done <= any_ack;
                        if (start) begin
                                spo <= '0;
                        end else if (any_ack) begin
                                spo <= ack_data;
                        end
                end
        end

        a_ack_onehot: assert property (@(posedge clk) disable iff (rst)
                $onehot0({slot_ack, miss_ack}))
                else $error("more than one acknowledge");

        // acceptance, strobe, acknowledge, done
        a_done_latency: assert property (@(posedge clk) disable iff (rst)
                start |-> ##3 done)
                else $error("transfer did not finish in 3 cycles");

endmodule

//--- test/lowmap_checker.sv
// ====================
// watches the host port of the decoder, models the banks and
// compares every completed transfer
// ====================

`timescale 1ns/1ps

module lowmap_checker (
        input  logic                       clk,
        input  logic                       rst,
        input  logic [bus_pkg::data_w-1:0] a,
        input  logic [bus_pkg::data_w-1:0] d,
        input  logic [bus_pkg::be_w-1:0]   web,
        input  logic                       rd,
        input  logic [bus_pkg::data_w-1:0] spo,
        input  logic                       ready,
        output int                         errors,
        output int                         checks
);
        import bus_pkg::*;
        import map_pkg::*;

        logic [data_w-1:0] model [num_slots][slot_words];
        logic              pending;
        int                low_cycles;
        int                owner_n;
        logic [data_w-1:0] exp_spo;
        bus_addr_u         req_a;

        // slot that owns a region, -1 for none
        function automatic int region_owner(input bus_addr_u ad);
                for (int i = 0; i < num_slots; i++) begin
                        if (ad.f.region == 16'(region_base + i * 16'h0100)) begin
                                return i;
                        end
                end
                return -1;
        endfunction

        function automatic logic [data_w-1:0] lane_merge(input logic [data_w-1:0] old_w,
                        input logic [data_w-1:0] new_w, input logic [be_w-1:0] be);
                logic [data_w-1:0] res;
                res = old_w;
                for (int b = 0; b < be_w; b++) begin
                        if (be[b]) begin
                                res[b*8 +: 8] = new_w[b*8 +: 8];
                        end
                end
                return res;
        endfunction

        // expected host answer, taken before the model sees the write
        function automatic logic [data_w-1:0] expected_spo(input bus_addr_u ad,
                        input logic [be_w-1:0] be);
                int sl;
                sl = region_owner(ad);
                if (sl < 0) begin
                        return unmapped_data;
                end
                if (|be) begin
                        return '0;
                end
                return model[sl][ad.f.offset[5:2]];
        endfunction

        always @(posedge clk) begin
                if (rst) begin
                        pending = 1'b0;
                        low_cycles = 0;
                        for (int sl = 0; sl < num_slots; sl++) begin
                                for (int w = 0; w < slot_words; w++) begin
                                        model[sl][w] = '0;
                                end
                        end
                end else if (pending) begin
                        if (ready) begin
                                checks++;
                                if (low_cycles != 3) begin
                                        errors++;
                                        $display("transfer to %08h returned ready after %0d cycles, not 3",
                                                req_a.raw, low_cycles);
                                end
                                if (spo !== exp_spo) begin
                                        errors++;
                                        $display("ERR %0t spo expected %08h actual %08h",
                                                $time, exp_spo, spo);
                                end
                                pending = 1'b0;
                        end else begin
                                low_cycles++;
                                if (low_cycles == 4) begin
                                        errors++;
                                        $display("ready stayed low more than 3 cycles after the request to %08h",
                                                req_a.raw);
                                end
                        end
                end else if ((|web) || rd) begin
                        // accepted, the mapper was idle
                        req_a.raw = a;
                        exp_spo = expected_spo(req_a, web);
                        owner_n = region_owner(req_a);
                        if (owner_n >= 0 && (|web)) begin
                                model[owner_n][req_a.f.offset[5:2]] = lane_merge(
                                        model[owner_n][req_a.f.offset[5:2]], d, web);
                        end
                        pending = 1'b1;
                        low_cycles = 0;
                end else if (!ready) begin
                        errors++;
                        $display("ready was low at %0t with no transfer in flight", $time);
                end
        end

endmodule

//--- test/tb_lowmap.sv
// ====================
// testbench for the peripheral decoder, directed and random host requests
// ====================

`timescale 1ns/1ps

module tb_lowmap;
        import bus_pkg::*;
        import map_pkg::*;

        localparam int n_sweep = num_slots * slot_words;
        localparam int n_full = 32;
        localparam int n_part = 48;
        localparam int n_alias = 24;
        localparam int n_miss = 16;
        localparam int n_mix = 160;
        localparam int n_xfers = 2 * n_sweep + n_full + n_part + n_alias + n_miss + n_mix;
        // a transfer spans 5 clock cycles
        localparam int watchdog_ns = (n_xfers + 20) * 5 * 40;

        logic              clk;
        logic              rst;
        logic [data_w-1:0] a;
        logic [data_w-1:0] d;
        logic [be_w-1:0]   web;
        logic              rd;
        logic [data_w-1:0] spo;
        logic              ready;
        int                errors;
        int                checks;
        logic [31:0]       rng;
        logic [31:0]       r;
        logic [31:0]       addr;
        logic [be_w-1:0]   be;
        int                s;

        lowmap_top uut (
                .clk   (clk),
                .rst   (rst),
                .a     (a),
                .d     (d),
                .web   (web),
                .rd    (rd),
                .spo   (spo),
                .ready (ready)
        );

        lowmap_checker chk (
                .clk    (clk),
                .rst    (rst),
                .a      (a),
                .d      (d),
                .web    (web),
                .rd     (rd),
                .spo    (spo),
                .ready  (ready),
                .errors (errors),
                .checks (checks)
        );

        always #20 clk = ~clk;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        function automatic logic [31:0] rand_word();
                rng = xorshift32(rng);
                return rng;
        endfunction

        // noise fills the offset bits outside the word index
        function automatic logic [31:0] slot_addr(input int sl, input logic [3:0] idx,
                        input logic [31:0] noise);
                bus_addr_u ad;
                ad.f.region = 16'(region_base + sl * 16'h0100);
                ad.f.offset = noise[15:0];
                ad.f.offset[5:2] = idx;
                return ad.raw;
        endfunction

        function automatic logic [31:0] miss_addr(input logic [31:0] noise);
                bus_addr_u ad;
                ad.raw = noise;
                for (int i = 0; i < num_slots; i++) begin
                        if (ad.f.region == 16'(region_base + i * 16'h0100)) begin
                                ad.f.region[0] = ~ad.f.region[0];
                        end
                end
                return ad.raw;
        endfunction

        // one idle cycle after ready so the checker sees the finish
        task automatic issue(input logic [31:0] ad, input logic [31:0] data,
                        input logic [be_w-1:0] lanes, input logic rd_i);
                @(negedge clk);
                while (!ready) begin
                        @(negedge clk);
                end
                @(negedge clk);
                a = ad;
                d = data;
                web = lanes;
                rd = rd_i;
                @(negedge clk);
                web = '0;
                rd = 1'b0;
        endtask

        task automatic write_req(input logic [31:0] ad, input logic [31:0] data,
                        input logic [be_w-1:0] lanes);
                issue(ad, data, lanes, 1'b0);
        endtask

        task automatic read_req(input logic [31:0] ad);
                issue(ad, 32'h0, '0, 1'b1);
        endtask

        task automatic read_all();
                for (int sl = 0; sl < num_slots; sl++) begin
                        for (int w = 0; w < slot_words; w++) begin
                                read_req(slot_addr(sl, 4'(w), rand_word()));
                        end
                end
        endtask

        initial begin
                clk = 1'b0;
                rst = 1'b1;
                a = '0;
                d = '0;
                web = '0;
                rd = 1'b0;
                rng = 32'h4911_9096;
                repeat (5) @(negedge clk);
                rst = 1'b0;
                // banks come out of reset cleared
                read_all();
                for (int k = 0; k < n_full / 2; k++) begin
                        s = k % num_slots;
                        r = rand_word();
                        addr = slot_addr(s, r[3:0], rand_word());
                        write_req(addr, rand_word(), 4'hf);
                        read_req(addr);
                end
                // single lanes and lane mixes
                for (int k = 0; k < n_part / 2; k++) begin
                        r = rand_word();
                        be = r[7:4];
                        if (be == '0 || &be) begin
                                be = 4'b0001 << r[9:8];
                        end
                        addr = slot_addr(int'(r[1:0]), r[13:10], rand_word());
                        write_req(addr, rand_word(), be);
                        read_req(addr);
                end
                // aliased offset, then the same index one region up
                for (int k = 0; k < n_alias / 3; k++) begin
                        s = k % num_slots;
                        r = rand_word();
                        addr = slot_addr(s, r[3:0], r);
                        write_req(addr, rand_word(), 4'hf);
                        read_req(addr ^ 32'h0000_ffc3);
                        read_req(slot_addr((s + 1) % num_slots, r[3:0], r));
                end
                for (int k = 0; k < n_miss; k++) begin
                        addr = miss_addr(rand_word());
                        if (k % 2 == 0) begin
                                write_req(addr, rand_word(), 4'hf);
                        end else begin
                                read_req(addr);
                        end
                end
                // about one in eight unmapped; rd with lanes set is a write
                for (int k = 0; k < n_mix; k++) begin
                        r = rand_word();
                        if (r[2:0] == 3'd0) begin
                                addr = miss_addr(rand_word());
                        end else begin
                                addr = slot_addr(int'(r[4:3]), r[8:5], rand_word());
                        end
                        issue(addr, rand_word(), r[12:9], r[13] | (r[12:9] == '0));
                end
                read_all();
                @(negedge clk);
                while (!ready) begin
                        @(negedge clk);
                end
                @(negedge clk);
                if (checks != n_xfers) begin
                        $display("only %0d of %0d transfers were checked", checks, n_xfers);
                end
                $display("errors %0d, checks %0d", errors, checks);
                if (errors == 0 && checks == n_xfers) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

        initial begin
                #(watchdog_ns);
                $display("watchdog expired at %0t before all transfers finished", $time);
                $display("errors %0d, checks %0d", errors, checks);
                $display("TEST RESULT: FAIL");
                $finish;
        end

endmodule
